// File: hw/afifo_pkg.sv
// Depth must be a power of two; all widths below derive from FIFO_DEPTH and DATA_WIDTH only
`default_nettype none

package afifo_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    // Number of words held, power of two
    localparam int FIFO_DEPTH = 16;

    // Memory address bits
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Address plus wrap bit to tell full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // Fill level counts 0 .. FIFO_DEPTH inclusive
    localparam int LEVEL_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Payload bits, last flag comes on top
    localparam int DATA_WIDTH = 8;

    // Receiving side synchronizer flops
    localparam int SYNC_STAGES = 2;

    // ------------------------------
    // Flag thresholds
    // ------------------------------

    // Almost-full when write level is at or above this
    localparam int ALMOST_FULL_LEVEL = 12;

    // Almost-empty when read level is at or below this
    localparam int ALMOST_EMPTY_LEVEL = 3;

    // ------------------------------
    // Vector types
    // ------------------------------

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Binary or Gray pointer
    typedef logic [PTR_WIDTH-1:0] ptr_t;

    typedef logic [LEVEL_WIDTH-1:0] level_t;

    // Stored word, bit DATA_WIDTH is the last flag
    typedef logic [DATA_WIDTH:0] entry_t;

endpackage : afifo_pkg

`default_nettype wire

// File: hw/gray_sync.sv
// Input must move by at most one step per source cycle; output lags by 1 source + SYNC_STAGES dest cycles
`default_nettype none

module gray_sync (
    input  logic            src_clk,
    input  logic            src_reset,
    input  logic            dst_clk,
    input  logic            dst_reset,
    input  afifo_pkg::ptr_t ptr_in,
    output afifo_pkg::ptr_t ptr_out
);

    // Source side Gray register
    afifo_pkg::ptr_t gray_q;

    // Destination synchronizer chain, index 0 is the first flop
    afifo_pkg::ptr_t sync_ff [afifo_pkg::SYNC_STAGES];

    // Adjacent codes differ in one bit only
    function automatic afifo_pkg::ptr_t bin_to_gray(input afifo_pkg::ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits from the top down to it
    function automatic afifo_pkg::ptr_t gray_to_bin(input afifo_pkg::ptr_t gray);
        afifo_pkg::ptr_t bin;
        bin[afifo_pkg::PTR_WIDTH-1] = gray[afifo_pkg::PTR_WIDTH-1];
        for (int i = afifo_pkg::PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // ------------------------------
    // Source domain
    // ------------------------------

    // Registered so no combinational glitch reaches the crossing
    always_ff @(posedge src_clk) begin
        if (src_reset) begin
            gray_q <= '0;
        end else begin
            gray_q <= bin_to_gray(ptr_in);
        end
    end

    // ------------------------------
    // Destination domain
    // ------------------------------

    always_ff @(posedge dst_clk) begin
        if (dst_reset) begin
            sync_ff <= '{default: '0};
        end else begin
            // First flop samples the asynchronous Gray value
            sync_ff[0] <= gray_q;
            for (int i = 1; i < afifo_pkg::SYNC_STAGES; i++) begin
                sync_ff[i] <= sync_ff[i-1];
            end
        end
    end

    // Back to binary for the level arithmetic
    assign ptr_out = gray_to_bin(sync_ff[afifo_pkg::SYNC_STAGES-1]);

endmodule : gray_sync

`default_nettype wire

// File: hw/afifo_ram.sv
// Array has no reset, so read data is undefined until the addressed entry has been written
`default_nettype none

module afifo_ram (
    input  logic              wclk,
    input  logic              rclk,
    input  logic              wen,
    input  afifo_pkg::addr_t  waddr,
    input  afifo_pkg::entry_t wdata,
    input  afifo_pkg::addr_t  raddr,
    output afifo_pkg::entry_t rdata
);

    // Storage, one entry per FIFO slot
    afifo_pkg::entry_t mem [afifo_pkg::FIFO_DEPTH];

    // ------------------------------
    // Write port
    // ------------------------------

    // Entry lands at the write clock edge
    always_ff @(posedge wclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Read every cycle, entry appears one rclk later
    // Holding raddr keeps rdata steady
    always_ff @(posedge rclk) begin
        rdata <= mem[raddr];
    end

endmodule : afifo_ram

`default_nettype wire

// File: hw/afifo_write_ctrl.sv
// Write side in one clock; rd_ptr_synced must already be in this domain, full test is conservative
`default_nettype none

module afifo_write_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              wvalid,
    input  afifo_pkg::ptr_t   rd_ptr_synced,
    output logic              wready,
    output afifo_pkg::ptr_t   wr_ptr,
    output logic              ram_wen,
    output afifo_pkg::addr_t  ram_waddr,
    output afifo_pkg::level_t wlevel,
    output logic              walmost_full
);

    logic            wr_handshake;
    afifo_pkg::ptr_t wr_ptr_next;
    logic            wready_next;
    logic            addr_match;
    logic            wrap_differs;

    // ------------------------------
    // Write pointer
    // ------------------------------

    // Word accepted on this edge
    assign wr_handshake = wvalid && wready;

    // Pointer after this cycle's write
    assign wr_ptr_next = wr_ptr + afifo_pkg::ptr_t'(wr_handshake);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_next;
        end
    end

    // Memory written at the current pointer
    assign ram_wen   = wr_handshake;
    assign ram_waddr = wr_ptr[afifo_pkg::ADDR_WIDTH-1:0];

    // ------------------------------
    // Full test and ready
    // ------------------------------

    // Full means same slot, opposite lap
    assign addr_match = (wr_ptr_next[afifo_pkg::ADDR_WIDTH-1:0]
                         == rd_ptr_synced[afifo_pkg::ADDR_WIDTH-1:0]);
    assign wrap_differs = (wr_ptr_next[afifo_pkg::PTR_WIDTH-1]
                           != rd_ptr_synced[afifo_pkg::PTR_WIDTH-1]);

    assign wready_next = !(addr_match && wrap_differs);

    // Low out of reset, rises one cycle after reset drops
    always_ff @(posedge clk) begin
        if (reset) begin
            wready <= 1'b0;
        end else begin
            wready <= wready_next;
        end
    end

    // ------------------------------
    // Level and almost-full
    // ------------------------------

    // Stale read pointer only ever overstates the level
    always_ff @(posedge clk) begin
        if (reset) begin
            wlevel <= '0;
        end else begin
            wlevel <= afifo_pkg::level_t'(wr_ptr - rd_ptr_synced);
        end
    end

    assign walmost_full = (wlevel >= afifo_pkg::level_t'(afifo_pkg::ALMOST_FULL_LEVEL));

endmodule : afifo_write_ctrl

`default_nettype wire

// File: hw/afifo_read_ctrl.sv
// Read side in one clock; wr_ptr_synced lags the writer, so rvalid and rlevel understate fill
`default_nettype none

module afifo_read_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              rready,
    input  afifo_pkg::ptr_t   wr_ptr_synced,
    output logic              rvalid,
    output afifo_pkg::ptr_t   rd_ptr_next,
    output afifo_pkg::addr_t  ram_raddr,
    output afifo_pkg::level_t rlevel,
    output logic              ralmost_empty
);

    afifo_pkg::ptr_t rd_ptr;
    afifo_pkg::ptr_t fill_next;
    logic            rd_handshake;

    // ------------------------------
    // Read pointer
    // ------------------------------

    // Word leaves on this edge
    assign rd_handshake = rvalid && rready;

    // Pointer after this cycle's read
    assign rd_ptr_next = rd_ptr + afifo_pkg::ptr_t'(rd_handshake);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr_next;
        end
    end

    // Memory addressed one step ahead
    // Its registered output then belongs to rd_ptr, the same cycle rvalid does
    assign ram_raddr = rd_ptr_next[afifo_pkg::ADDR_WIDTH-1:0];

    // ------------------------------
    // Valid request
    // ------------------------------

    // Words left once this cycle's read is taken out
    assign fill_next = wr_ptr_synced - rd_ptr_next;

    // Held while stalled because rd_ptr_next stops moving
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= |fill_next;
        end
    end

    // ------------------------------
    // Level and almost-empty
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            rlevel <= '0;
        end else begin
            rlevel <= afifo_pkg::level_t'(fill_next);
        end
    end

    // High out of reset since rlevel is zero
    assign ralmost_empty = (rlevel <= afifo_pkg::level_t'(afifo_pkg::ALMOST_EMPTY_LEVEL));

endmodule : afifo_read_ctrl

`default_nettype wire

// File: hw/afifo_top.sv
// Two unrelated clocks, each reset synchronous in its own domain; reset both before traffic starts
`default_nettype none

module afifo_top (
    input  logic              src_clk,
    input  logic              src_reset,
    input  logic              dst_clk,
    input  logic              dst_reset,

    // Write port, src_clk domain
    input  logic              wvalid,
    output logic              wready,
    input  afifo_pkg::data_t  wdata,
    input  logic              wlast,
    output logic              walmost_full,
    output afifo_pkg::level_t wlevel,

    // Read port, dst_clk domain
    output logic              rvalid,
    input  logic              rready,
    output afifo_pkg::data_t  rdata,
    output logic              rlast,
    output logic              ralmost_empty,
    output afifo_pkg::level_t rlevel
);

    // Pointers and their synchronized copies
    afifo_pkg::ptr_t   wr_ptr;
    afifo_pkg::ptr_t   wr_ptr_synced;
    afifo_pkg::ptr_t   rd_ptr_next;
    afifo_pkg::ptr_t   rd_ptr_synced;

    // Memory ports
    logic              ram_wen;
    afifo_pkg::addr_t  ram_waddr;
    afifo_pkg::addr_t  ram_raddr;
    afifo_pkg::entry_t ram_wdata;
    afifo_pkg::entry_t ram_rdata;

    // ------------------------------
    // Write domain
    // ------------------------------

    afifo_write_ctrl u_write_ctrl (
        .clk          (src_clk),
        .reset        (src_reset),
        .wvalid       (wvalid),
        .rd_ptr_synced(rd_ptr_synced),
        .wready       (wready),
        .wr_ptr       (wr_ptr),
        .ram_wen      (ram_wen),
        .ram_waddr    (ram_waddr),
        .wlevel       (wlevel),
        .walmost_full (walmost_full)
    );

    // Last flag stored on top of the data
    assign ram_wdata = {wlast, wdata};

    // ------------------------------
    // Crossings
    // ------------------------------

    // Write pointer towards the reader
    gray_sync u_wr_ptr_sync (
        .src_clk  (src_clk),
        .src_reset(src_reset),
        .dst_clk  (dst_clk),
        .dst_reset(dst_reset),
        .ptr_in   (wr_ptr),
        .ptr_out  (wr_ptr_synced)
    );

    // Read pointer towards the writer, launched from dst_clk
    gray_sync u_rd_ptr_sync (
        .src_clk  (dst_clk),
        .src_reset(dst_reset),
        .dst_clk  (src_clk),
        .dst_reset(src_reset),
        .ptr_in   (rd_ptr_next),
        .ptr_out  (rd_ptr_synced)
    );

    // ------------------------------
    // Storage and read domain
    // ------------------------------

    afifo_ram u_ram (
        .wclk (src_clk),
        .rclk (dst_clk),
        .wen  (ram_wen),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .raddr(ram_raddr),
        .rdata(ram_rdata)
    );

    afifo_read_ctrl u_read_ctrl (
        .clk          (dst_clk),
        .reset        (dst_reset),
        .rready       (rready),
        .wr_ptr_synced(wr_ptr_synced),
        .rvalid       (rvalid),
        .rd_ptr_next  (rd_ptr_next),
        .ram_raddr    (ram_raddr),
        .rlevel       (rlevel),
        .ralmost_empty(ralmost_empty)
    );

    // Memory output goes straight to the port
    assign rdata = ram_rdata[afifo_pkg::DATA_WIDTH-1:0];
    assign rlast = ram_rdata[afifo_pkg::DATA_WIDTH];

endmodule : afifo_top

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Free-running clock from time zero; the phase offset delays the first rising edge by that many ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20,
    parameter int PHASE_NS  = 0
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // Low through the offset, then a rising edge every period
    initial begin
        clk = 1'b0;
        #(PHASE_NS);
        forever begin
            #(PERIOD_NS / 2);
            clk = 1'b1;
            #(PERIOD_NS / 2);
            clk = 1'b0;
        end
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: dv/tb_afifo.sv
// Run from the project root so dv/afifo_vectors.txt resolves; needs at least 37 vector lines
`default_nettype none

module tb_afifo;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES    = 64;
    localparam int STREAM_LINES = 20;
    localparam int WAIT_LIMIT   = 200;
    localparam int DRIVE_DELAY  = 1;

    logic              src_clk;
    logic              dst_clk;
    logic              src_reset;
    logic              dst_reset;
    logic              wvalid;
    logic              wready;
    afifo_pkg::data_t  wdata;
    logic              wlast;
    logic              walmost_full;
    afifo_pkg::level_t wlevel;
    logic              rvalid;
    logic              rready;
    afifo_pkg::data_t  rdata;
    logic              rlast;
    logic              ralmost_empty;
    afifo_pkg::level_t rlevel;

    // Raw file words, four per line: data, last, gap, stall
    logic [7:0]        vec_raw [4*MAX_LINES];
    afifo_pkg::data_t  vec_data [MAX_LINES];
    logic              vec_last [MAX_LINES];
    int                vec_gap [MAX_LINES];
    int                vec_stall [MAX_LINES];
    int                n_lines;

    // Model queue holds vector line numbers in write order
    int                model_q [$];
    int                writes_accepted;
    int                seed;
    logic              monitor_on;
    int                full_base;

    int                data_errors;
    int                last_errors;
    int                level_errors;
    int                flag_errors;
    int                timeout_errors;

    // ------------------------------
    // Clocks and DUT
    // ------------------------------

    tb_clock_gen #(.PERIOD_NS(20), .PHASE_NS(0)) u_src_clock (.clk(src_clk));
    // Read clock skewed by 7 ns
    tb_clock_gen #(.PERIOD_NS(20), .PHASE_NS(7)) u_dst_clock (.clk(dst_clk));

    afifo_top DUT (
        .src_clk      (src_clk),
        .src_reset    (src_reset),
        .dst_clk      (dst_clk),
        .dst_reset    (dst_reset),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wlast        (wlast),
        .walmost_full (walmost_full),
        .wlevel       (wlevel),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rlast        (rlast),
        .ralmost_empty(ralmost_empty),
        .rlevel       (rlevel)
    );

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_data(input afifo_pkg::data_t got, input afifo_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %02h, expected %02h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0b, expected %0b", $time, what, got, exp);
            last_errors++;
        end
    endtask

    task automatic check_level(input afifo_pkg::level_t got, input afifo_pkg::level_t exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            level_errors++;
        end
    endtask

    // Ready, valid and almost flags
    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0b, expected %0b", $time, what, got, exp);
            flag_errors++;
        end
    endtask

    // ------------------------------
    // Helpers
    // ------------------------------

    // Every drive happens just after a rising edge
    task automatic src_step();
        @(posedge src_clk);
        #(DRIVE_DELAY);
    endtask

    task automatic dst_step();
        @(posedge dst_clk);
        #(DRIVE_DELAY);
    endtask

    // Unused slots keep 8'hee, which no last field holds
    task automatic load_vectors();
        for (int a = 0; a < 4 * MAX_LINES; a++) begin
            vec_raw[a] = 8'hee;
        end
        $readmemh("dv/afifo_vectors.txt", vec_raw);
        n_lines = 0;
        while (n_lines < MAX_LINES && vec_raw[4*n_lines+1] <= 8'h01) begin
            vec_data[n_lines]  = vec_raw[4*n_lines];
            vec_last[n_lines]  = vec_raw[4*n_lines+1][0];
            vec_gap[n_lines]   = int'(vec_raw[4*n_lines+2]);
            vec_stall[n_lines] = int'(vec_raw[4*n_lines+3]);
            n_lines++;
        end
    endtask

    // Gap first, then wvalid held until wready takes the word
    task automatic send_words(input int first, input int count);
        int   cycles;
        logic taken;
        src_step();
        for (int i = first; i < first + count; i++) begin
            if (vec_gap[i] > 0) begin
                wvalid = 1'b0;
                repeat (vec_gap[i]) src_step();
            end
            wvalid = 1'b1;
            wdata  = vec_data[i];
            wlast  = vec_last[i];
            taken  = 1'b0;
            cycles = 0;
            while (!taken && cycles < WAIT_LIMIT) begin
                // wready is registered, so its value now holds at the next edge
                taken = wready;
                src_step();
                cycles++;
            end
            if (taken) begin
                model_q.push_back(i);
                writes_accepted++;
            end else begin
                $display("Timeout waiting for wready to take vector line %0d", i);
                timeout_errors++;
            end
        end
        wvalid = 1'b0;
    endtask

    // Stall per line, plus an occasional random hold
    task automatic receive_words(input int first, input int count, input logic random_holds);
        int               hold;
        int               cycles;
        int               exp_line;
        logic             taken;
        afifo_pkg::data_t got_data;
        logic             got_last;
        dst_step();
        for (int i = first; i < first + count; i++) begin
            hold = vec_stall[i];
            if (random_holds && (($random(seed) & 3) == 0)) begin
                hold = hold + 1;
            end
            if (hold > 0) begin
                rready = 1'b0;
                repeat (hold) dst_step();
            end
            rready = 1'b1;
            taken  = 1'b0;
            cycles = 0;
            while (!taken && cycles < WAIT_LIMIT) begin
                taken    = rvalid;
                got_data = rdata;
                got_last = rlast;
                dst_step();
                cycles++;
            end
            if (!taken) begin
                $display("Timeout waiting for rvalid on read of line %0d", i);
                timeout_errors++;
            end else if (model_q.size() == 0) begin
                $display("Read handshake at %0t with no word left in the model", $time);
                data_errors++;
            end else begin
                exp_line = model_q.pop_front();
                check_data(got_data, vec_data[exp_line], "rdata");
                check_last(got_last, vec_last[exp_line], "rlast");
            end
        end
        rready = 1'b0;
    endtask

    // Reads held off: exactly FIFO_DEPTH writes go in, then wready stays low
    task automatic fill_and_hold(input int base);
        int cycles;
        src_step();
        cycles = 0;
        while (writes_accepted - base < afifo_pkg::FIFO_DEPTH && cycles < WAIT_LIMIT) begin
            src_step();
            cycles++;
        end
        if (writes_accepted - base < afifo_pkg::FIFO_DEPTH) begin
            $display("Timeout waiting for the FIFO to fill while reads are held off");
            timeout_errors++;
        end
        cycles = 0;
        while (wlevel != afifo_pkg::level_t'(afifo_pkg::FIFO_DEPTH) && cycles < WAIT_LIMIT) begin
            src_step();
            cycles++;
        end
        if (wlevel != afifo_pkg::level_t'(afifo_pkg::FIFO_DEPTH)) begin
            $display("Timeout waiting for wlevel to report a full FIFO");
            timeout_errors++;
        end
        repeat (10) begin
            src_step();
            check_flag(wready, 1'b0, "wready while full");
        end
        check_level(afifo_pkg::level_t'(writes_accepted - base),
                    afifo_pkg::level_t'(afifo_pkg::FIFO_DEPTH), "writes accepted while full");
        check_level(rlevel, afifo_pkg::level_t'(afifo_pkg::FIFO_DEPTH), "rlevel while full");
    endtask

    // Both ports idle long enough for the pointers to cross
    task automatic check_settled_levels(input string when);
        repeat (afifo_pkg::SYNC_STAGES + 3) src_step();
        repeat (afifo_pkg::SYNC_STAGES + 3) dst_step();
        check_level(wlevel, afifo_pkg::level_t'(model_q.size()), {"wlevel ", when});
        check_level(rlevel, afifo_pkg::level_t'(model_q.size()), {"rlevel ", when});
    endtask

    task automatic print_counts();
        $display("errors: data %0d, last %0d, level %0d, flag %0d, timeout %0d",
                 data_errors, last_errors, level_errors, flag_errors, timeout_errors);
    endtask

    // ------------------------------
    // Almost flag monitors
    // ------------------------------

    always @(posedge src_clk) begin
        #2;
        if (monitor_on) begin
            check_flag(walmost_full,
                       wlevel >= afifo_pkg::level_t'(afifo_pkg::ALMOST_FULL_LEVEL),
                       "walmost_full");
        end
    end

    always @(posedge dst_clk) begin
        #2;
        if (monitor_on) begin
            check_flag(ralmost_empty,
                       rlevel <= afifo_pkg::level_t'(afifo_pkg::ALMOST_EMPTY_LEVEL),
                       "ralmost_empty");
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        src_reset       = 1'b1;
        dst_reset       = 1'b1;
        wvalid          = 1'b0;
        wdata           = '0;
        wlast           = 1'b0;
        rready          = 1'b0;
        monitor_on      = 1'b0;
        seed            = 32'h447013cc;
        writes_accepted = 0;
        data_errors     = 0;
        last_errors     = 0;
        level_errors    = 0;
        flag_errors     = 0;
        timeout_errors  = 0;
        load_vectors();
        if (n_lines < STREAM_LINES + afifo_pkg::FIFO_DEPTH + 1) begin
            $display("Vector file holds only %0d lines, too few for the full test", n_lines);
            data_errors++;
        end

        // Each reset held for 3 edges of its own clock
        fork
            begin
                repeat (3) src_step();
                src_reset = 1'b0;
                check_flag(wready, 1'b0, "wready after reset");
                check_flag(walmost_full, 1'b0, "walmost_full after reset");
                check_level(wlevel, '0, "wlevel after reset");
                src_step();
                check_flag(wready, 1'b1, "wready one cycle after reset");
            end
            begin
                repeat (3) dst_step();
                dst_reset = 1'b0;
                check_flag(rvalid, 1'b0, "rvalid after reset");
                check_flag(ralmost_empty, 1'b1, "ralmost_empty after reset");
                check_level(rlevel, '0, "rlevel after reset");
            end
        join
        monitor_on = 1'b1;

        // Streaming with gaps, stalls and random read holds
        fork
            send_words(0, STREAM_LINES);
            receive_words(0, STREAM_LINES, 1'b1);
        join
        check_settled_levels("after streaming");

        // Fill against a stopped reader, then drain
        full_base = writes_accepted;
        fork
            send_words(STREAM_LINES, n_lines - STREAM_LINES);
            begin
                fill_and_hold(full_base);
                receive_words(STREAM_LINES, n_lines - STREAM_LINES, 1'b0);
            end
        join
        check_settled_levels("after drain");

        monitor_on = 1'b0;
        print_counts();
        if (data_errors + last_errors + level_errors + flag_errors + timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Last resort if the sequence itself stops moving
    initial begin
        #400us;
        $display("Simulation did not finish within 400 us");
        print_counts();
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_afifo

`default_nettype wire

// File: dv/afifo_vectors.txt
// Hex columns: data, last flag, write gap cycles, read stall cycles
// Lines 00-13 stream, lines 14-27 fill a stopped reader and then drain
3c 0 0 0
a7 0 1 0
51 0 0 2
e2 1 2 0
0f 0 0 1
98 0 0 0
6d 0 3 0
c4 1 0 8
13 0 0 0
7e 0 1 0
b9 0 0 3
25 1 0 0
f0 0 2 0
4a 0 0 0c
86 0 0 0
d1 0 1 1
2b 0 0 0
5f 1 0 2
9c 0 4 0
00 1 0 0
ff 0 0 0
11 0 0 1
22 0 0 0
33 1 0 0
44 0 0 2
55 0 0 0
66 0 0 0
77 1 0 1
88 0 0 0
99 0 0 0
aa 0 0 3
bb 1 0 0
cc 0 0 0
dd 0 0 0
ee 0 0 1
01 1 0 0
80 0 1 0
40 0 0 2
20 0 2 0
10 1 0 0

// File: compile.f
hw/afifo_pkg.sv
hw/gray_sync.sv
hw/afifo_ram.sv
hw/afifo_write_ctrl.sv
hw/afifo_read_ctrl.sv
hw/afifo_top.sv
dv/tb_clock_gen.sv
dv/tb_afifo.sv

// File: Makefile
# Verilator build and run of the dual-clock FIFO testbench, started from the project root
TOP := tb_afifo
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "No pass message in $(LOG)"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module afifo_top hw/afifo_pkg.sv hw/gray_sync.sv \
		hw/afifo_ram.sv hw/afifo_write_ctrl.sv hw/afifo_read_ctrl.sv hw/afifo_top.sv
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
